// ==== Bender.yml ====
package:
  name: motor_six_step

export_include_dirs:
  - include

sources:
  - design/motorPkg.sv
  - design/uartPkg.sv
  - design/timebase.sv
  - design/commutationSequencer.sv
  - design/gateDriver.sv
  - design/configReporter.sv
  - design/uartTx.sv
  - design/motorTop.sv
  - target: test
    files:
      - bench/uartFrameMonitor.sv
      - bench/motorTopTb.sv

// ==== all.f ====
+incdir+include
design/motorPkg.sv
design/uartPkg.sv
design/timebase.sv
design/commutationSequencer.sv
design/gateDriver.sv
design/configReporter.sv
design/uartTx.sv
design/motorTop.sv
bench/uartFrameMonitor.sv
bench/motorTopTb.sv

// ==== bench/motorTopTb.sv ====
`timescale 1ns/10ps

`include "motor_defs.svh"

module motorTopTb;

    localparam int Phases = 12;
    localparam int StepsPerPhase = 40;
    localparam int DeadCycles = `DEAD_TICKS * `CLK_DIV;
    // Longest phase plus one frame, then slack for reset and the first frame.
    localparam longint TimeoutCycles = Phases * (StepsPerPhase * 64 * `CLK_DIV + 2000) + 5000;

    logic                    clk50mhz;
    logic                    rst;
    logic                    start;
    logic                    invOrStop;
    logic [`SPEED_WIDTH-1:0] speed;
    logic                    aH, aL, bH, bL, cH, cL;
    logic                    uTx;
    logic [3:0]              led4;
    logic                    frameDone;
    logic [31:0]             frameData;
    logic                    midByte;
    logic                    framingErr;

    longint      cycles = 0;
    longint      liveCycles = 0;
    int          phaseId = 0;
    logic [31:0] expQ[$];

    motorTop uut (
        .clk50mhz, .rst, .start, .invOrStop, .speed,
        .aH, .aL, .bH, .bL, .cH, .cL, .uTx, .led4
    );

    uartFrameMonitor mon (.clk50mhz, .rst, .uTx, .frameDone, .frameData, .midByte, .framingErr);

    always #5 clk50mhz = ~clk50mhz;

    task automatic stopRun(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    // Gate bits in {aH, aL, bH, bL, cH, cL} order for each step.
    function automatic int patternIndex(input logic [5:0] g);
        case (g)
            6'b100100: return 0;
            6'b100001: return 1;
            6'b001001: return 2;
            6'b011000: return 3;
            6'b010010: return 4;
            6'b000110: return 5;
            default:   return -1;
        endcase
    endfunction

    function automatic logic [31:0] expectedFrame(input logic s, input logic inv,
                                                  input logic [`SPEED_WIDTH-1:0] spd);
        return {`FRAME_HEADER, s, inv, 6'b0, 6'b0, spd[9:8], spd[7:0]};
    endfunction

    always @(posedge clk50mhz) begin
        cycles <= cycles + 1;
        if (!rst) begin
            liveCycles <= liveCycles + 1;
        end
        if (cycles >= TimeoutCycles) begin
            stopRun("Timeout: the run did not finish within its cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks.
    //////////////////////////////////////////////////////////////////////

    logic [5:0] cur, prev = '0;
    int         seenPhase = 0, lastIdx, idx, riseCount = 0, curSpan = 0;
    logic       curStart = 1'b0, curInv = 1'b0;
    logic       haveDrop = 1'b0, haveIdx = 1'b0, haveRise = 1'b0;
    longint     dropTime, lastRise, phaseSeen = 0;
    logic [31:0] want;

    always @(negedge clk50mhz) begin
        if (!rst) begin
            cur = {aH, aL, bH, bL, cH, cL};
            if (phaseId != seenPhase) begin
                seenPhase = phaseId;
                phaseSeen = cycles;
                curStart  = start;
                curInv    = invOrStop;
                curSpan   = `STEP_SPAN - speed;
                haveIdx   = 1'b0;
                haveRise  = 1'b0;
                riseCount = 0;
            end
            assert (!(aH && aL) && !(bH && bL) && !(cH && cL))
                else stopRun($sformatf("Error: gates shoot-through, gates=%h", cur));
            if (cur != prev) begin
                if ((cur & ~prev) == '0) begin
                    dropTime = cycles;
                    haveDrop = (cur != '0);
                end else begin
                    idx = patternIndex(cur);
                    assert (idx >= 0)
                        else stopRun($sformatf("Error: gates pattern invalid, gates=%h", cur));
                    // A rise may land on the clock that clears running.
                    assert (led4[1] || (!curStart && cycles - phaseSeen <= 1))
                        else stopRun($sformatf("Error: led4 running bit, led4=%h", led4));
                    if (haveDrop) begin
                        assert (cycles - dropTime == DeadCycles)
                            else stopRun($sformatf("Error: dead time, got=%h want=%h",
                                                   cycles - dropTime, DeadCycles));
                    end
                    if (haveIdx) begin
                        assert (idx == (curInv ? (lastIdx + 5) % 6 : (lastIdx + 1) % 6))
                            else stopRun($sformatf("Error: step order, step=%h last=%h",
                                                   idx, lastIdx));
                    end
                    if (haveRise) begin
                        assert (cycles - lastRise == curSpan * `CLK_DIV)
                            else stopRun($sformatf("Error: step interval, got=%h want=%h",
                                                   cycles - lastRise, curSpan * `CLK_DIV));
                    end
                    lastIdx   = idx;
                    lastRise  = cycles;
                    haveIdx   = 1'b1;
                    // Only a step event inside this phase starts a timed interval.
                    haveRise  = (cycles - phaseSeen > DeadCycles);
                    haveDrop  = 1'b0;
                    riseCount = riseCount + 1;
                end
            end
            prev = cur;
            if (!curStart && cycles - phaseSeen >= 2) begin
                assert (cur == '0 && !led4[1])
                    else stopRun($sformatf("Error: stopped outputs, gates=%h led4=%h", cur, led4));
            end
            if (cycles - phaseSeen >= 1) begin
                assert (led4[2] == invOrStop)
                    else stopRun($sformatf("Error: led4 reverse bit, led4=%h", led4));
            end
            assert (led4[0] == liveCycles[`HEARTBEAT_BIT])
                else stopRun($sformatf("Error: led4 heartbeat bit, led4=%h", led4));
            if (midByte) begin
                assert (led4[3])
                    else stopRun($sformatf("Error: led4 busy bit, led4=%h", led4));
            end
            assert (!framingErr)
                else stopRun("The UART line carried a malformed start or stop bit");
            if (frameDone) begin
                assert (expQ.size() > 0)
                    else stopRun("A status frame arrived with no configuration change");
                want = expQ.pop_front();
                assert (frameData == want)
                    else stopRun($sformatf("Error: frame, got=%h want=%h", frameData, want));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus.
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic                    nStart;
        logic                    nInv;
        logic [`SPEED_WIDTH-1:0] nSpeed;
        int                      span;
        longint                  phaseStart;
        clk50mhz  = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        invOrStop = 1'b0;
        speed     = '0;
        void'($urandom(32'h097d_abb8));
        expQ.push_back(expectedFrame(1'b0, 1'b0, '0));
        repeat (5) @(posedge clk50mhz);
        @(negedge clk50mhz);
        rst = 1'b0;
        while (expQ.size() > 0) @(negedge clk50mhz);
        for (int p = 0; p < Phases; p++) begin
            @(negedge clk50mhz);
            nStart = ($urandom % 4) != 0;
            nInv   = 1'($urandom % 2);
            nSpeed = `SPEED_WIDTH'(960 + $urandom % 64);
            if ({nStart, nInv, nSpeed} != {start, invOrStop, speed}) begin
                expQ.push_back(expectedFrame(nStart, nInv, nSpeed));
            end
            start      = nStart;
            invOrStop  = nInv;
            speed      = nSpeed;
            phaseId    = phaseId + 1;
            phaseStart = cycles;
            span       = `STEP_SPAN - nSpeed;
            while (cycles - phaseStart < StepsPerPhase * span * `CLK_DIV + 100
                   || expQ.size() > 0) begin
                @(negedge clk50mhz);
            end
            if (nStart && span > `DEAD_TICKS) begin
                assert (riseCount >= StepsPerPhase - 10)
                    else stopRun($sformatf("Error: step count, got=%h", riseCount));
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== bench/uartFrameMonitor.sv ====
`timescale 1ns/10ps

`include "motor_defs.svh"

module uartFrameMonitor (
    input  logic        clk50mhz,
    input  logic        rst,
    input  logic        uTx,
    output logic        frameDone,
    output logic [31:0] frameData,
    output logic        midByte,
    output logic        framingErr
);

    initial begin
        frameDone  = 1'b0;
        frameData  = '0;
        midByte    = 1'b0;
        framingErr = 1'b0;
    end

    // Line is sampled on the falling clock edge, away from its updates.
    always begin : rxLoop
        logic [7:0]  rxByte;
        logic [31:0] acc;
        int          n;
        int          i;
        acc = '0;
        for (n = 0; n < 4; n++) begin
            do begin
                @(negedge clk50mhz);
            end while (rst || uTx !== 1'b0);
            midByte <= 1'b1;
            // Move to the middle of the start bit.
            repeat (`BAUD_DIV / 2) @(negedge clk50mhz);
            if (uTx !== 1'b0) begin
                framingErr <= 1'b1;
            end
            for (i = 0; i < 8; i++) begin
                repeat (`BAUD_DIV) @(negedge clk50mhz);
                rxByte[i] = uTx;
            end
            repeat (`BAUD_DIV) @(negedge clk50mhz);
            if (uTx !== 1'b1) begin
                framingErr <= 1'b1;
            end
            midByte <= 1'b0;
            acc = {acc[23:0], rxByte};
        end
        frameData <= acc;
        frameDone <= 1'b1;
        @(negedge clk50mhz);
        frameDone <= 1'b0;
    end

endmodule

// ==== design/commutationSequencer.sv ====
`timescale 1ns/10ps

`include "motor_defs.svh"

module commutationSequencer
    import motorPkg::*;
(
    input  logic     clk50mhz,
    input  logic     rst,
    input  logic     tick10,
    input  motorCfgT cfg,
    output logic     stepEvt,
    output stepT     step,
    output logic     running
);

    logic                    active;
    logic                    dirQ;
    logic                    dirChange;
    logic [`SPEED_WIDTH-1:0] span;
    logic [`SPEED_WIDTH-1:0] intervalCnt;
    stepT                    stepQ;
    stepT                    stepNxt;

    //////////////////////////////////////////////////////////////////////
    // Interval and event decode.
    //////////////////////////////////////////////////////////////////////

    assign active    = cfg.start && (cfg.speed != '0);
    assign span      = `SPEED_WIDTH'(`STEP_SPAN - cfg.speed);
    assign dirChange = running && (cfg.invOrStop != dirQ);

    // First tick after start fires at once.
    assign stepEvt = active && tick10 && !dirChange && (!running || intervalCnt == 1);

    always_comb begin
        if (!running) begin
            stepNxt = stepQ;
        end else if (cfg.invOrStop) begin
            stepNxt = (stepQ == 3'd0) ? 3'd5 : stepQ - 3'd1;
        end else begin
            stepNxt = (stepQ == 3'd5) ? 3'd0 : stepQ + 3'd1;
        end
    end

    // New index is visible during the event cycle.
    assign step = stepEvt ? stepNxt : stepQ;

    //////////////////////////////////////////////////////////////////////
    // State.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk50mhz) begin
        if (rst) begin
            running     <= 1'b0;
            stepQ       <= '0;
            intervalCnt <= '0;
            dirQ        <= 1'b0;
        end else begin
            dirQ <= cfg.invOrStop;
            if (!active) begin
                running <= 1'b0;
            end else if (stepEvt) begin
                running     <= 1'b1;
                stepQ       <= stepNxt;
                intervalCnt <= span;
            end else if (dirChange) begin
                intervalCnt <= span;
            end else if (tick10 && running) begin
                intervalCnt <= intervalCnt - 1'b1;
            end
        end
    end

    stepInRange: assert property (@(posedge clk50mhz) disable iff (rst) step <= 3'd5)
        else $error("step index out of range");

endmodule

// ==== design/configReporter.sv ====
`timescale 1ns/10ps

module configReporter
    import motorPkg::*;
    import uartPkg::*;
(
    input  logic     clk50mhz,
    input  logic     rst,
    input  motorCfgT cfg,
    input  logic     busy,
    output uartByteT byteOut
);

    motorCfgT   sentCfg;
    frameT      frame;
    frameT      newFrame;
    logic       pending;
    logic       inFrame;
    logic [1:0] byteIdx;
    logic       txIdle;

    assign newFrame = packFrame(cfg.start, cfg.invOrStop, cfg.speed);

    // Wait one cycle after a strobe for busy to rise.
    assign txIdle = !busy && !byteOut.send;

    always_ff @(posedge clk50mhz) begin
        if (rst) begin
            sentCfg      <= '0;
            pending      <= 1'b1;
            inFrame      <= 1'b0;
            byteIdx      <= '0;
            byteOut.send <= 1'b0;
        end else begin
            byteOut.send <= 1'b0;
            if (txIdle) begin
                if (inFrame) begin
                    byteOut.send <= 1'b1;
                    byteIdx      <= byteIdx + 1'b1;
                    if (byteIdx == 2'd3) begin
                        inFrame <= 1'b0;
                    end
                end else if (pending || cfg != sentCfg) begin
                    // Snapshot taken as the header goes out.
                    sentCfg      <= cfg;
                    pending      <= 1'b0;
                    inFrame      <= 1'b1;
                    byteIdx      <= 2'd1;
                    byteOut.send <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk50mhz) begin
        if (txIdle && !inFrame) begin
            frame        <= newFrame;
            byteOut.data <= newFrame[0];
        end else if (txIdle) begin
            byteOut.data <= frame[byteIdx];
        end
    end

endmodule

// ==== design/gateDriver.sv ====
`timescale 1ns/10ps

`include "motor_defs.svh"

module gateDriver
    import motorPkg::*;
(
    input  logic  clk50mhz,
    input  logic  rst,
    input  logic  tick10,
    input  logic  stepEvt,
    input  stepT  step,
    input  logic  running,
    output gatesT gates
);

    localparam int DeadW = $clog2(`DEAD_TICKS + 1);

    gatesT            target;
    gatesT            nextPattern;
    logic             pending;
    logic [DeadW-1:0] deadCnt;

    assign nextPattern = stepPattern(step);

    //////////////////////////////////////////////////////////////////////
    // Break before make.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk50mhz) begin
        if (rst) begin
            gates   <= '0;
            pending <= 1'b0;
            deadCnt <= '0;
        end else if (stepEvt) begin
            // Keep only gates shared with the next step.
            gates   <= gates & nextPattern;
            pending <= 1'b1;
            deadCnt <= DeadW'(`DEAD_TICKS);
        end else if (!running) begin
            gates   <= '0;
            pending <= 1'b0;
        end else if (pending && tick10) begin
            if (deadCnt == 1) begin
                gates   <= target;
                pending <= 1'b0;
            end else begin
                deadCnt <= deadCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk50mhz) begin
        if (stepEvt) begin
            target <= nextPattern;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bridge safety.
    //////////////////////////////////////////////////////////////////////

    noShootThrough: assert property (@(posedge clk50mhz) disable iff (rst)
        !(gates.a.high && gates.a.low) && !(gates.b.high && gates.b.low)
        && !(gates.c.high && gates.c.low))
        else $error("leg shoot-through");

    // Each rise ends the dead time that a step event started.
    riseNeedsEvt: assert property (@(posedge clk50mhz) disable iff (rst)
        |(gates & ~$past(gates)) |-> $past(stepEvt, `DEAD_TICKS * `CLK_DIV + 1))
        else $error("gate rose without a step event");

endmodule

// ==== design/motorPkg.sv ====
package motorPkg;

`include "motor_defs.svh"

    // Commutation index, 0 to 5.
    typedef logic [2:0] stepT;

    typedef struct packed {
        logic high;
        logic low;
    } legT;

    typedef struct packed {
        legT a;
        legT b;
        legT c;
    } gatesT;

    typedef struct packed {
        logic                    start;
        logic                    invOrStop;
        logic [`SPEED_WIDTH-1:0] speed;
    } motorCfgT;

    // One high-side and one low-side gate per step.
    function automatic gatesT stepPattern(input stepT s);
        gatesT g;
        g = '0;
        case (s)
            3'd0: begin g.a.high = 1'b1; g.b.low = 1'b1; end
            3'd1: begin g.a.high = 1'b1; g.c.low = 1'b1; end
            3'd2: begin g.b.high = 1'b1; g.c.low = 1'b1; end
            3'd3: begin g.b.high = 1'b1; g.a.low = 1'b1; end
            3'd4: begin g.c.high = 1'b1; g.a.low = 1'b1; end
            3'd5: begin g.c.high = 1'b1; g.b.low = 1'b1; end
            default: g = '0;
        endcase
        return g;
    endfunction

endpackage

// ==== design/motorTop.sv ====
`timescale 1ns/10ps

`include "motor_defs.svh"

module motorTop
    import motorPkg::*;
    import uartPkg::*;
(
    input  logic                    clk50mhz,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    invOrStop,
    input  logic [`SPEED_WIDTH-1:0] speed,
    output logic                    aH,
    output logic                    aL,
    output logic                    bH,
    output logic                    bL,
    output logic                    cH,
    output logic                    cL,
    output logic                    uTx,
    output logic [3:0]              led4
);

    motorCfgT cfg;
    gatesT    gates;
    stepT     step;
    uartByteT txByte;
    logic     tick10;
    logic     heartbeat;
    logic     stepEvt;
    logic     running;
    logic     busy;

    assign cfg = {start, invOrStop, speed};

    timebase tb (.clk50mhz, .rst, .tick10, .heartbeat);

    commutationSequencer seq (.clk50mhz, .rst, .tick10, .cfg, .stepEvt, .step, .running);

    gateDriver gd (.clk50mhz, .rst, .tick10, .stepEvt, .step, .running, .gates);

    configReporter rep (.clk50mhz, .rst, .cfg, .busy, .byteOut(txByte));

    uartTx tx (.clk50mhz, .rst, .byteIn(txByte), .busy, .uTx);

    // Struct order is a, b, c with high before low.
    assign {aH, aL, bH, bL, cH, cL} = gates;

    assign led4 = {busy, invOrStop, running, heartbeat};

endmodule

// ==== design/timebase.sv ====
`timescale 1ns/10ps

`include "motor_defs.svh"

module timebase (
    input  logic clk50mhz,
    input  logic rst,
    output logic tick10,
    output logic heartbeat
);

    localparam int DivW = $clog2(`CLK_DIV);

    logic [DivW-1:0]           divCnt;
    logic [`HEARTBEAT_BIT:0]   hbCnt;

    // One strobe per CLK_DIV cycles stands in for the 10 MHz clock.
    always_ff @(posedge clk50mhz) begin
        if (rst) begin
            divCnt <= '0;
            tick10 <= 1'b0;
            hbCnt  <= '0;
        end else begin
            hbCnt <= hbCnt + 1'b1;
            if (divCnt == DivW'(`CLK_DIV - 1)) begin
                divCnt <= '0;
                tick10 <= 1'b1;
            end else begin
                divCnt <= divCnt + 1'b1;
                tick10 <= 1'b0;
            end
        end
    end

    assign heartbeat = hbCnt[`HEARTBEAT_BIT];

endmodule

// ==== design/uartPkg.sv ====
package uartPkg;

`include "motor_defs.svh"

    // Byte 0 is the header, sent first.
    typedef logic [0:3][7:0] frameT;

    typedef struct packed {
        logic       send;
        logic [7:0] data;
    } uartByteT;

    function automatic frameT packFrame(input logic start, input logic invOrStop,
                                        input logic [`SPEED_WIDTH-1:0] speed);
        frameT f;
        f[0] = `FRAME_HEADER;
        f[1] = {start, invOrStop, 6'b0};
        f[2] = 8'(speed >> 8);
        f[3] = speed[7:0];
        return f;
    endfunction

endpackage

// ==== design/uartTx.sv ====
`timescale 1ns/10ps

`include "motor_defs.svh"

module uartTx
    import uartPkg::*;
(
    input  logic     clk50mhz,
    input  logic     rst,
    input  uartByteT byteIn,
    output logic     busy,
    output logic     uTx
);

    localparam int BaudW = $clog2(`BAUD_DIV);

    logic [BaudW-1:0] baudCnt;
    logic [3:0]       bitCnt;
    logic [9:0]       shifter;

    // Line follows bit 0; idle shifter is all ones.
    assign uTx = shifter[0];

    always_ff @(posedge clk50mhz) begin
        if (rst) begin
            busy    <= 1'b0;
            baudCnt <= '0;
            bitCnt  <= '0;
            shifter <= '1;
        end else if (!busy) begin
            if (byteIn.send) begin
                shifter <= {1'b1, byteIn.data, 1'b0};
                busy    <= 1'b1;
                baudCnt <= '0;
                bitCnt  <= '0;
            end
        end else if (baudCnt == BaudW'(`BAUD_DIV - 1)) begin
            baudCnt <= '0;
            shifter <= {1'b1, shifter[9:1]};
            bitCnt  <= bitCnt + 1'b1;
            if (bitCnt == 4'd9) begin
                busy <= 1'b0;
            end
        end else begin
            baudCnt <= baudCnt + 1'b1;
        end
    end

    noSendWhileBusy: assert property (@(posedge clk50mhz) disable iff (rst)
        byteIn.send |-> !busy)
        else $error("byte offered while transmitter busy");

endmodule

// ==== include/motor_defs.svh ====
`ifndef MOTOR_DEFS_SVH
`define MOTOR_DEFS_SVH

// clk50mhz cycles per tick10 strobe.
`define CLK_DIV 5

// Width of the operator speed setting.
`define SPEED_WIDTH 10

// Ticks per commutation step are STEP_SPAN minus speed.
`define STEP_SPAN 1024

// Ticks a gate waits before it turns on.
`define DEAD_TICKS 4

// clk50mhz cycles per UART bit, short for simulation.
`define BAUD_DIV 16

// First byte of every status frame.
`define FRAME_HEADER 8'hA5

// Free-running counter bit shown as heartbeat.
`define HEARTBEAT_BIT 22

`endif
